// File: pokey_input.f
pokey_pkg.sv
pokey_timebase.sv
pokey_pin_cond.sv
pokey_key_scan.sv
pokey_pot_scan.sv
pokey_reg_read.sv
pokey_input_top.sv
pokey_input_properties.sv
tb_pokey_input.sv

// File: Makefile
TOP   = tb_pokey_input
FLIST = pokey_input.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_pokey_input.sv
`timescale 1ns/1ps

module tb_pokey_input;
    import pokey_pkg::*;

    // watchdog budget is reads per test times cycles per read for every test
    localparam int num_tests       = 6;
    localparam int reads_per_test  = 10;
    localparam int cycles_per_read = 4000;

    typedef struct packed {
        reg_addr_t  addr;
        logic [7:0] got;
        logic [7:0] exp;
        logic [1:0] tol;
    } rd_item_t;

    logic     clk = 1'b0;
    logic     rst;
    pad_in_t  pad_in;
    logic     potgo;
    logic     trig_latch_en;
    rd_req_t  rd;
    pad_out_t pad_out;
    rd_rsp_t  rsp;

    // pins driven by the controller models
    logic       kr1_n    = 1'b1;
    logic [1:0] pot_line = 2'b00;
    logic [3:0] trig_n;
    logic       top_btn_n;

    // model state the reference works from
    logic        key_down = 1'b0;
    logic [3:0]  key      = 4'h0;
    logic [3:0]  exp_key  = 4'h0;
    logic        exp_depr = 1'b0;
    logic        top_exp  = 1'b0;
    logic [3:0]  exp_trig = 4'h0;
    logic        pots_ran = 1'b0;
    // pots expected to be still waiting for their line
    logic [1:0]  exp_busy = 2'b00;
    // -1 marks a pot whose line never charges
    int          pot_tgt [2] = '{-1, -1};
    int          rel_clks = 0;
    logic [31:0] lfsr = 32'h4763_9f9a;
    rd_item_t    cmp_q [$];
    rd_item_t    item_c;

    always #4 clk = ~clk;

    assign pad_in = '{kr1_n: kr1_n, pot_line: pot_line, trig_n: trig_n, top_btn_n: top_btn_n};

    pokey_input_top pokey_input_top_inst (
        .clk           (clk),
        .rst           (rst),
        .pad_in        (pad_in),
        .potgo         (potgo),
        .trig_latch_en (trig_latch_en),
        .rd            (rd),
        .pad_out       (pad_out),
        .rsp           (rsp)
    );

    // keypad matrix pulls the return line low while the scan sits on the held key
    always @(posedge clk) begin
        kr1_n <= !(key_down && (pad_out.key_scan == key));
    end

    // pot caps charge a set number of ticks after release and are dumped when pot_rel drops
    always @(posedge clk) begin
        if (!pad_out.pot_rel) begin
            rel_clks <= 0;
            pot_line <= 2'b00;
        end else begin
            rel_clks <= rel_clks + 1;
            for (int i = 0; i < 2; i++) begin
                pot_line[i] <= (pot_tgt[i] >= 0) && (rel_clks >= pot_tgt[i] * tick_div);
            end
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // expected register contents from the model state
    function automatic logic [7:0] ref_value(reg_addr_t addr);
        logic [7:0] v;
        case (addr)
            addr_pot0, addr_pot1: begin
                if (!pots_ran) v = 8'h00;
                else if (pot_tgt[addr[0]] < 0) v = 8'(pot_max);
                else v = 8'(pot_tgt[addr[0]]);
            end
            addr_allpot: v = {6'b0, exp_busy};
            addr_kbcode: v = {top_exp, top_exp, 1'b0, exp_key, 1'b0};
            addr_trig:   v = {4'h0, exp_trig};
            addr_skstat: v = 8'hFF & ~{5'b0, exp_depr, 2'b0};
            default:     v = 8'h00;
        endcase
        return v;
    endfunction

    // a charging pot may land one tick late or early
    function automatic int pot_tol(reg_addr_t addr);
        if ((addr == addr_pot0 || addr == addr_pot1) && pots_ran && pot_tgt[addr[0]] >= 0) begin
            return 1;
        end else begin
            return 0;
        end
    endfunction

    task automatic fail_run(string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(string what, logic [7:0] got, logic [7:0] exp, int tol);
        int diff;
        diff = int'(got) - int'(exp);
        if (diff > tol || diff < -tol) begin
            $display("ERR %0t %s: got %02h expected %02h", $time, what, got, exp);
            fail_run("register value mismatch");
        end
    endtask

    task automatic wait_ticks(int n);
        repeat (n * tick_div) @(posedge clk);
    endtask

    // four-phase read that is entered and left on a rising edge
    task automatic read_reg(input reg_addr_t addr, input int hold, output logic [7:0] data);
        int waited;
        check_value("ack high before a new req", 8'(rsp.ack), 8'h00, 0);
        rd <= '{req: 1'b1, addr: addr};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) fail_run("read port never raised ack");
        end while (!rsp.ack);
        data = rsp.data;
        repeat (hold) @(posedge clk);
        rd.req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 50) fail_run("read port never dropped ack");
        end while (rsp.ack);
    endtask

    task automatic read_expect(reg_addr_t addr, int hold);
        logic [7:0] d;
        read_reg(addr, hold, d);
        cmp_q.push_back('{addr: addr, got: d, exp: ref_value(addr), tol: 2'(pot_tol(addr))});
    endtask

    // comparing process drains the queue of finished reads
    always @(posedge clk) begin
        while (cmp_q.size() > 0) begin
            item_c = cmp_q.pop_front();
            check_value($sformatf("read of reg %h", item_c.addr), item_c.got, item_c.exp,
                        int'(item_c.tol));
        end
    end

    task automatic test_keypad();
        logic [3:0] k;
        for (int n = 0; n < 4; n++) begin
            k = 4'(rand_bits(4));
            key <= k;
            key_down <= 1'b1;
            // a partial pass plus two full passes for acceptance
            wait_ticks(3 * num_keys + deb_ticks);
            exp_key = k;
            exp_depr = 1'b1;
            read_expect(addr_kbcode, 0);
            read_expect(addr_skstat, 0);
            key_down <= 1'b0;
            wait_ticks(2 * num_keys + deb_ticks);
            exp_depr = 1'b0;
            read_expect(addr_skstat, 0);
            read_expect(addr_kbcode, 0);
        end
    endtask

    task automatic test_top_btn();
        top_btn_n <= 1'b0;
        wait_ticks(deb_ticks + 2);
        top_exp = 1'b1;
        read_expect(addr_kbcode, 0);
        top_btn_n <= 1'b1;
        wait_ticks(deb_ticks + 2);
        top_exp = 1'b0;
        read_expect(addr_kbcode, 0);
    endtask

    task automatic wait_allpot_clear();
        logic [7:0] d;
        int polls;
        polls = 0;
        d = 8'hFF;
        while (d != 8'h00) begin
            if (polls > pot_max + 8) fail_run("ALLPOT did not clear after potgo");
            wait_ticks(1);
            read_reg(addr_allpot, 0, d);
            polls++;
        end
    endtask

    // second run leaves pot1 uncharged so it runs to the last count
    task automatic test_pots();
        for (int run = 0; run < 2; run++) begin
            while (pad_out.pot_rel) @(posedge clk);
            pot_tgt[0] = int'(rand_bits(8) % 200) + 4;
            pot_tgt[1] = (run == 0) ? int'(rand_bits(8) % 200) + 4 : -1;
            potgo <= 1'b1;
            @(posedge clk);
            potgo <= 1'b0;
            pots_ran = 1'b1;
            // targets start at 4 ticks, so both pots are still charging here
            exp_busy = 2'b11;
            read_expect(addr_allpot, 0);
            wait_allpot_clear();
            exp_busy = 2'b00;
            read_expect(addr_pot0, 0);
            read_expect(addr_pot1, 0);
        end
    endtask

    task automatic test_trig();
        logic [3:0] pat;
        int b;
        pat = 4'(rand_bits(4)) | 4'h1;
        trig_n <= ~pat;
        wait_ticks(deb_ticks + 2);
        exp_trig = pat;
        read_expect(addr_trig, 0);
        trig_n <= 4'hF;
        wait_ticks(deb_ticks + 2);
        exp_trig = 4'h0;
        read_expect(addr_trig, 0);
        // press and release one trigger with latch mode on
        b = int'(rand_bits(2));
        trig_latch_en <= 1'b1;
        trig_n <= ~(4'h1 << b);
        wait_ticks(deb_ticks + 2);
        trig_n <= 4'hF;
        wait_ticks(deb_ticks + 2);
        exp_trig = 4'h1 << b;
        read_expect(addr_trig, 0);
        trig_latch_en <= 1'b0;
        repeat (2) @(posedge clk);
        exp_trig = 4'h0;
        read_expect(addr_trig, 0);
    endtask

    initial begin
        rst = 1'b1;
        potgo = 1'b0;
        trig_latch_en = 1'b0;
        rd = '0;
        trig_n = 4'hF;
        top_btn_n = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // the scan address starts at 0 after reset
        check_value("key_scan after reset", 8'(pad_out.key_scan), 8'h00, 0);
        // reset state reads where 4'h5 is an unmapped address
        read_expect(addr_pot0, 0);
        read_expect(addr_pot1, 0);
        read_expect(addr_allpot, 0);
        read_expect(addr_skstat, 0);
        read_expect(addr_trig, 0);
        read_expect(4'h5, 0);
        test_keypad();
        test_top_btn();
        test_pots();
        test_trig();
        // back-to-back reads with a random hold before req drops
        for (int i = 0; i < 8; i++) begin
            read_expect(4'(rand_bits(4)), int'(rand_bits(3)));
        end
        repeat (2) @(posedge clk);
        if (pokey_input_top_inst.pokey_input_properties_inst.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (num_tests * reads_per_test * cycles_per_read) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

// File: pokey_input_properties.sv
`timescale 1ns/1ps

module pokey_input_properties (
    input logic                clk,
    input logic                rst,
    input pokey_pkg::rd_req_t  rd,
    input pokey_pkg::rd_rsp_t  rsp,
    input pokey_pkg::pad_out_t pad_out
);

    // failed assertions so far
    int unsigned fail_cnt = 0;

    // ack only comes up in answer to a request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(rsp.ack) |-> rd.req
    ) else begin
        fail_cnt++;
        $error("ack rose with req low");
    end

    // response data held for the whole ack phase
    data_held: assert property (
        @(posedge clk) disable iff (rst) (rsp.ack && $past(rsp.ack)) |-> $stable(rsp.data)
    ) else begin
        fail_cnt++;
        $error("rsp.data changed while ack was high");
    end

    // reset leaves the port idle and the pots dumped
    reset_idle: assert property (
        @(posedge clk) rst |=> (!rsp.ack && !pad_out.pot_rel)
    ) else begin
        fail_cnt++;
        $error("ack or pot_rel high after reset");
    end

endmodule

bind pokey_input_top pokey_input_properties pokey_input_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd),
    .rsp     (rsp),
    .pad_out (pad_out)
);

// File: pokey_input_top.sv
`timescale 1ns/1ps

module pokey_input_top (
    input  logic                clk,
    input  logic                rst,
    input  pokey_pkg::pad_in_t  pad_in,
    input  logic                potgo,
    input  logic                trig_latch_en,
    input  pokey_pkg::rd_req_t  rd,
    output pokey_pkg::pad_out_t pad_out,
    output pokey_pkg::rd_rsp_t  rsp
);
    import pokey_pkg::*;

    logic                  tick;
    pins_t                 pins;
    key_stat_t             key_stat;
    pot_stat_t             pot_stat;
    logic [key_addr_w-1:0] key_scan;
    logic                  pot_rel;

    // scan enable, shared by every block below
    pokey_timebase pokey_timebase_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    pokey_pin_cond pokey_pin_cond_inst (
        .clk           (clk),
        .rst           (rst),
        .tick          (tick),
        .pad_in        (pad_in),
        .trig_latch_en (trig_latch_en),
        .pins          (pins)
    );

    pokey_key_scan pokey_key_scan_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .kr1      (pins.kr1),
        .top_btn  (pins.top_btn),
        .key_scan (key_scan),
        .key_stat (key_stat)
    );

    pokey_pot_scan pokey_pot_scan_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .potgo    (potgo),
        .pot_line (pins.pot_line),
        .pot_rel  (pot_rel),
        .pot_stat (pot_stat)
    );

    // host side
    pokey_reg_read pokey_reg_read_inst (
        .clk      (clk),
        .rst      (rst),
        .rd       (rd),
        .key_stat (key_stat),
        .pot_stat (pot_stat),
        .trig     (pins.trig),
        .rsp      (rsp)
    );

    // controller drive pins
    assign pad_out = '{
        key_scan: key_scan,
        pot_rel:  pot_rel
    };

endmodule

// File: pokey_reg_read.sv
`timescale 1ns/1ps

module pokey_reg_read (
    input  logic                  clk,
    input  logic                  rst,
    input  pokey_pkg::rd_req_t    rd,
    input  pokey_pkg::key_stat_t  key_stat,
    input  pokey_pkg::pot_stat_t  pot_stat,
    input  logic [3:0]            trig,
    output pokey_pkg::rd_rsp_t    rsp
);
    import pokey_pkg::*;

    typedef enum logic {
        st_idle,
        st_ack
    } state_t;

    state_t     state;
    logic [7:0] sel_data;
    logic [7:0] data_q;

    // register decode
    always_comb begin
        case (rd.addr)
            addr_pot0:   sel_data = pot_stat.pot0;
            addr_pot1:   sel_data = pot_stat.pot1;
            addr_allpot: sel_data = pot_stat.allpot;
            addr_kbcode: sel_data = key_stat.kbcode;
            addr_trig:   sel_data = {4'b0, trig};
            // skstat bit 2 is low while a key is down
            addr_skstat: sel_data = key_stat.key_depr ? 8'hFB : 8'hFF;
            default:     sel_data = 8'h00;
        endcase
    end

    // four-phase handshake
    // idle -> ack on req, ack -> idle once req is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (rd.req) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (!rd.req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // snapshot at the start of the request, held for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == st_idle && rd.req) begin
            data_q <= sel_data;
        end
    end

    assign rsp = '{
        ack:  (state == st_ack),
        data: data_q
    };

endmodule

// File: pokey_pot_scan.sv
`timescale 1ns/1ps

module pokey_pot_scan (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  potgo,
    input  logic [1:0]            pot_line,
    output logic                  pot_rel,
    output pokey_pkg::pot_stat_t  pot_stat
);
    import pokey_pkg::*;

    // shared pot counter
    logic [7:0] cnt;
    logic       at_max;

    // one bit per pot still waiting for its line, this is ALLPOT 1:0
    logic [1:0] scanning;

    logic [7:0] pot0_q;
    logic [7:0] pot1_q;

    assign at_max = (cnt == 8'(pot_max));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            scanning <= '0;
            pot_rel  <= 1'b0;
            pot0_q   <= '0;
            pot1_q   <= '0;
        end else if (potgo) begin
            // start or restart, release the capacitors
            cnt      <= '0;
            scanning <= 2'b11;
            pot_rel  <= 1'b1;
        end else if (tick && pot_rel) begin
            if (!at_max) begin
                cnt <= cnt + 8'd1;
            end
            // first tick with the line high latches the count
            // at the last count a slow pot latches pot_max
            if (scanning[0] && (pot_line[0] || at_max)) begin
                pot0_q      <= cnt;
                scanning[0] <= 1'b0;
            end
            if (scanning[1] && (pot_line[1] || at_max)) begin
                pot1_q      <= cnt;
                scanning[1] <= 1'b0;
            end
            if (at_max) begin
                // scan over, dump the pots
                pot_rel <= 1'b0;
            end
        end
    end

    assign pot_stat = '{
        pot0:   pot0_q,
        pot1:   pot1_q,
        allpot: {6'b0, scanning}
    };

endmodule

// File: pokey_key_scan.sv
`timescale 1ns/1ps

module pokey_key_scan (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic                  kr1,
    input  logic                  top_btn,
    output logic [3:0]            key_scan,
    output pokey_pkg::key_stat_t  key_stat
);
    import pokey_pkg::*;

    // hits so far in this pass: 0, 1, or 2 meaning two or more
    logic [1:0]            hit_cnt;
    logic [key_addr_w-1:0] hit_addr;

    // result of the previous pass
    logic                  prev_one;
    logic [key_addr_w-1:0] prev_addr;

    logic [key_addr_w-1:0] keycode;
    logic                  key_depr;

    // this pass including the sample taken on the current tick
    logic [1:0]            pass_cnt;
    logic [key_addr_w-1:0] pass_addr;
    logic                  pass_end;
    logic                  accept;

    always_comb begin
        pass_cnt  = hit_cnt;
        pass_addr = hit_addr;
        if (kr1) begin
            pass_addr = key_scan;
            if (hit_cnt != 2'd2) begin
                pass_cnt = hit_cnt + 2'd1;
            end
        end
    end

    assign pass_end = (key_scan == key_addr_w'(num_keys - 1));

    // same single key on two passes in a row
    assign accept = pass_end && (pass_cnt == 2'd1) && prev_one && (pass_addr == prev_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            key_scan <= '0;
            hit_cnt  <= '0;
            prev_one <= 1'b0;
            key_depr <= 1'b0;
            keycode  <= '0;
        end else if (tick) begin
            // sample for this address is taken, move on
            key_scan <= key_scan + 1'b1;
            if (pass_end) begin
                hit_cnt  <= '0;
                prev_one <= (pass_cnt == 2'd1);
                if (accept) begin
                    keycode  <= pass_addr;
                    key_depr <= 1'b1;
                end else if (pass_cnt == 2'd0) begin
                    // nothing pressed, keycode stays as it was
                    key_depr <= 1'b0;
                end
            end else begin
                hit_cnt <= pass_cnt;
            end
        end
    end

    // matching addresses, only meaningful next to the counts above
    always_ff @(posedge clk) begin
        if (tick) begin
            hit_addr <= pass_addr;
            if (pass_end) begin
                prev_addr <= pass_addr;
            end
        end
    end

    // kbcode layout: 7:6 top button, 4:1 key address
    assign key_stat = '{
        kbcode:   {top_btn, top_btn, 1'b0, keycode, 1'b0},
        key_depr: key_depr
    };

endmodule

// File: pokey_pin_cond.sv
`timescale 1ns/1ps

module pokey_pin_cond (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  pokey_pkg::pad_in_t pad_in,
    input  logic              trig_latch_en,
    output pokey_pkg::pins_t   pins
);
    import pokey_pkg::*;

    // two-flop synchroniser on the whole pad bundle
    pad_in_t sync1;
    pad_in_t sync2;

    // buttons in active-high form: top button in bit 4, triggers in 3:0
    logic [4:0]                btn_raw;
    logic [4:0]                btn_db;
    logic [4:0][deb_cnt_w-1:0] deb_cnt;

    // trigger bits as presented to the register file
    logic [3:0] trig_q;

    always_ff @(posedge clk) begin
        sync1 <= pad_in;
        sync2 <= sync1;
    end

    assign btn_raw = {~sync2.top_btn_n, ~sync2.trig_n};

    // per-button debouncer, counts ticks spent away from the accepted level
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_db  <= '0;
            deb_cnt <= '0;
        end else if (tick) begin
            for (int i = 0; i < $bits(btn_db); i++) begin
                if (btn_raw[i] == btn_db[i]) begin
                    // bounce back, start over
                    deb_cnt[i] <= '0;
                end else if (deb_cnt[i] == deb_cnt_w'(deb_ticks - 1)) begin
                    btn_db[i]  <= btn_raw[i];
                    deb_cnt[i] <= '0;
                end else begin
                    deb_cnt[i] <= deb_cnt[i] + 1'b1;
                end
            end
        end
    end

    // latch mode holds any trigger once pressed
    // leaving latch mode drops straight back to the live buttons
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_q <= '0;
        end else if (trig_latch_en) begin
            trig_q <= trig_q | btn_db[3:0];
        end else begin
            trig_q <= btn_db[3:0];
        end
    end

    // kr1 and the pot lines are only synchronised:
    // kr1 is low for one scan tick per pass and is qualified by the two-pass check,
    // the pot lines are timed per tick and a debounce would skew the counts
    assign pins = '{
        kr1:      ~sync2.kr1_n,
        pot_line: sync2.pot_line,
        trig:     trig_q,
        top_btn:  btn_db[4]
    };

endmodule

// File: pokey_timebase.sv
`timescale 1ns/1ps

module pokey_timebase (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    import pokey_pkg::*;

    // free running divider, one clock enable per wrap
    logic [tick_cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            // tick is registered so every consumer sees a clean one-cycle pulse
            tick <= (cnt == tick_cnt_w'(tick_div - 1));
            if (cnt == tick_cnt_w'(tick_div - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: pokey_pkg.sv
package pokey_pkg;

    // clocks per scan tick, kept short for simulation
    localparam int tick_div = 16;
    localparam int tick_cnt_w = $clog2(tick_div);

    // ticks a button must hold a new level before it is taken
    localparam int deb_ticks = 4;
    localparam int deb_cnt_w = $clog2(deb_ticks);

    // last pot count, a pot still charging here reads this value
    localparam int pot_max = 228;

    // keypad matrix positions and scan address width
    localparam int num_keys = 16;
    localparam int key_addr_w = $clog2(num_keys);

    typedef logic [3:0] reg_addr_t;

    // read-only register map
    localparam reg_addr_t addr_pot0   = 4'h0;
    localparam reg_addr_t addr_pot1   = 4'h1;
    localparam reg_addr_t addr_allpot = 4'h8;
    localparam reg_addr_t addr_kbcode = 4'h9;
    localparam reg_addr_t addr_trig   = 4'hA;
    localparam reg_addr_t addr_skstat = 4'hF;

    // raw controller pins as they arrive from the connector
    typedef struct packed {
        logic       kr1_n;
        logic [1:0] pot_line;
        logic [3:0] trig_n;
        logic       top_btn_n;
    } pad_in_t;

    // pins driven back to the controller
    typedef struct packed {
        logic [key_addr_w-1:0] key_scan;
        logic                  pot_rel;
    } pad_out_t;

    // conditioned pins, all active high
    typedef struct packed {
        logic       kr1;
        logic [1:0] pot_line;
        logic [3:0] trig;
        logic       top_btn;
    } pins_t;

    typedef struct packed {
        logic [7:0] kbcode;
        logic       key_depr;
    } key_stat_t;

    typedef struct packed {
        logic [7:0] pot0;
        logic [7:0] pot1;
        logic [7:0] allpot;
    } pot_stat_t;

    typedef struct packed {
        logic      req;
        reg_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] data;
    } rd_rsp_t;

endpackage
